//--- rtl/dma_config.svh
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// number of request/acknowledge channel pairs
`define DMA_CHANNELS 4

// memory address and word count width
`define DMA_ADDR_WIDTH 16

// cpu data bus width, half of the address width
`define DMA_DATA_WIDTH 8

`endif

//--- rtl/dmaBusPkg.sv
package dmaBusPkg;

  // bus cycle run for each transfer, 8237 mode bits 3:2
  typedef enum logic [1:0]
  {
    typeVerify = 2'b00,
    typeWrite  = 2'b01,
    typeRead   = 2'b10
  } transferTypeE;

  // service mode, mode bits 7:6
  // demand and cascade are run like single
  typedef enum logic [1:0]
  {
    modeDemand  = 2'b00,
    modeSingle  = 2'b01,
    modeBlock   = 2'b10,
    modeCascade = 2'b11
  } transferModeE;

endpackage

//--- rtl/dmaRegPkg.sv
`include "dma_config.svh"

package dmaRegPkg;

  import dmaBusPkg::*;

  // per-channel mode, stored without the channel select bits
  typedef struct packed
  {
    transferModeE transferMode;
    logic         addrDecrement;
    logic         autoInit;
    transferTypeE transferType;
  } dmaModeT;

  typedef struct packed
  {
    logic [2:0] reservedHigh;
    logic       rotatingPriority;
    logic       reservedMid;
    logic       controllerDisable;
    logic [1:0] reservedLow;
  } dmaCommandT;

  // request bits live, terminal count bits sticky until read
  typedef struct packed
  {
    logic [`DMA_CHANNELS-1:0] request;
    logic [`DMA_CHANNELS-1:0] reachedTc;
  } dmaStatusT;

  typedef struct packed
  {
    dmaModeT    mode;
    logic [1:0] channel;
  } dmaModeWriteT;

  // byte on the data bus, raw or as a mode write
  typedef union packed
  {
    logic [`DMA_DATA_WIDTH-1:0] raw;
    dmaModeWriteT               modeWrite;
  } dmaWriteByteT;

endpackage

//--- rtl/dmaDatapath.sv
`timescale 1ns/1ps
`include "dma_config.svh"

module dmaDatapath
  import dmaRegPkg::*;
(
  input  logic                                cpuIf,
  input  logic                                rstN,
  input  logic                                csN,
  input  logic                                iorN,
  input  logic                                iowN,
  input  logic [3:0]                          addrLow,
  input  logic [`DMA_DATA_WIDTH-1:0]          dbIn,
  output logic [`DMA_DATA_WIDTH-1:0]          dbOut,
  output logic                                dbOutEn,
  input  logic [`DMA_CHANNELS-1:0]            dreq,
  input  logic                                programEn,
  input  logic [$clog2(`DMA_CHANNELS)-1:0]    svcChannel,
  input  logic                                svcUpdate,
  output dmaCommandT                          commandReg,
  output dmaModeT                             svcMode,
  output logic [`DMA_ADDR_WIDTH-1:0]          memAddr,
  output logic                                tcNow
);

  localparam int chanW = $clog2(`DMA_CHANNELS);
  localparam int addrW = `DMA_ADDR_WIDTH;
  localparam int dataW = `DMA_DATA_WIDTH;

  logic [addrW-1:0] baseAddr  [`DMA_CHANNELS];
  logic [addrW-1:0] curAddr   [`DMA_CHANNELS];
  logic [addrW-1:0] baseCount [`DMA_CHANNELS];
  logic [addrW-1:0] curCount  [`DMA_CHANNELS];
  dmaModeT          modeReg   [`DMA_CHANNELS];

  logic [`DMA_CHANNELS-1:0] tcReached;
  logic                     byteFf;
  dmaWriteByteT             wrByte;
  dmaStatusT                statusNow;

  logic             access;
  logic             wrStb;
  logic             rdStb;
  logic             chanAccess;
  logic             cmdWr;
  logic             modeWr;
  logic             ffClr;
  logic             statusRd;
  logic [chanW-1:0] regChan;
  logic             countSel;
  logic [addrW-1:0] readWord;
  logic [dataW-1:0] readByte;

  // replace one byte lane of a 16-bit register
  function automatic logic [addrW-1:0] mergeByte(
    input logic [addrW-1:0] word,
    input logic [dataW-1:0] data,
    input logic             highByte
  );
    logic [addrW-1:0] result;
    result = word;
    if (highByte)
      result[addrW-1:dataW] = data;
    else
      result[dataW-1:0] = data;
    return result;
  endfunction

  // strobe decode, only one of ior/iow may be active
  assign access     = !csN && (iorN ^ iowN) && programEn;
  assign wrStb      = access && !iowN;
  assign rdStb      = access && !iorN;
  assign chanAccess = !addrLow[3];
  assign regChan    = addrLow[2:1];
  assign countSel   = addrLow[0];
  assign cmdWr      = wrStb && (addrLow == 4'd8);
  assign modeWr     = wrStb && (addrLow == 4'd11);
  assign ffClr      = wrStb && (addrLow == 4'd12);
  assign statusRd   = rdStb && (addrLow == 4'd8);

  assign wrByte.raw = dbIn;

  assign statusNow.request   = dreq;
  assign statusNow.reachedTc = tcReached;

  // serviced channel view for timing control and the address bus
  assign svcMode = modeReg[svcChannel];
  assign memAddr = curAddr[svcChannel];
  assign tcNow   = (curCount[svcChannel] == '0);

  // byte pointer, low byte first
  always_ff @(posedge cpuIf)
  begin
    if (!rstN || ffClr)
      byteFf <= 1'b0;
    else if (access && chanAccess)
      byteFf <= !byteFf;
  end

  always_ff @(posedge cpuIf)
  begin
    if (!rstN)
      commandReg <= '0;
    else if (cmdWr)
      commandReg <= dmaCommandT'(wrByte.raw);
  end

  // mode byte carries its own channel number
  always_ff @(posedge cpuIf)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < `DMA_CHANNELS; i++)
        modeReg[i] <= '0;
    end
    else if (modeWr)
      modeReg[wrByte.modeWrite.channel] <= wrByte.modeWrite.mode;
  end

  // address and count registers, cpu writes or transfer stepping
  always_ff @(posedge cpuIf)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < `DMA_CHANNELS; i++)
      begin
        baseAddr[i]  <= '0;
        curAddr[i]   <= '0;
        baseCount[i] <= '0;
        curCount[i]  <= '0;
      end
    end
    else if (wrStb && chanAccess)
    begin
      if (countSel)
      begin
        baseCount[regChan] <= mergeByte(baseCount[regChan], dbIn, byteFf);
        curCount[regChan]  <= mergeByte(curCount[regChan], dbIn, byteFf);
      end
      else
      begin
        baseAddr[regChan] <= mergeByte(baseAddr[regChan], dbIn, byteFf);
        curAddr[regChan]  <= mergeByte(curAddr[regChan], dbIn, byteFf);
      end
    end
    else if (svcUpdate)
    begin
      if (tcNow && svcMode.autoInit)
      begin
        curAddr[svcChannel]  <= baseAddr[svcChannel];
        curCount[svcChannel] <= baseCount[svcChannel];
      end
      else
      begin
        if (svcMode.addrDecrement)
          curAddr[svcChannel] <= curAddr[svcChannel] - 1'b1;
        else
          curAddr[svcChannel] <= curAddr[svcChannel] + 1'b1;
        // wraps to all ones after terminal count without auto-init
        curCount[svcChannel] <= curCount[svcChannel] - 1'b1;
      end
    end
  end

  // terminal count flags, cleared by a status read
  always_ff @(posedge cpuIf)
  begin
    if (!rstN)
      tcReached <= '0;
    else if (svcUpdate && tcNow)
      tcReached[svcChannel] <= 1'b1;
    else if (statusRd)
      tcReached <= '0;
  end

  // read-back byte select
  always_comb
  begin
    readWord = countSel ? curCount[regChan] : curAddr[regChan];
    if (chanAccess)
      readByte = byteFf ? readWord[addrW-1:dataW] : readWord[dataW-1:0];
    else if (addrLow == 4'd8)
      readByte = statusNow;
    else
      readByte = '0;
  end

  always_ff @(posedge cpuIf)
  begin
    if (!rstN)
      dbOutEn <= 1'b0;
    else
      dbOutEn <= rdStb;
  end

  always_ff @(posedge cpuIf)
  begin
    if (rdStb)
      dbOut <= readByte;
  end

endmodule

//--- rtl/dmaPriority.sv
`timescale 1ns/1ps
`include "dma_config.svh"

module dmaPriority
(
  input  logic                             cpuIf,
  input  logic                             rstN,
  input  logic [`DMA_CHANNELS-1:0]         dreq,
  input  logic                             rotatingPriority,
  input  logic                             svcUpdate,
  input  logic [$clog2(`DMA_CHANNELS)-1:0] svcChannel,
  output logic [`DMA_CHANNELS-1:0]         winner
);

  localparam int chanW = $clog2(`DMA_CHANNELS);

  logic [chanW-1:0] lastChannel;

  // starts at the top channel so rotation begins at channel 0
  always_ff @(posedge cpuIf)
  begin
    if (!rstN)
      lastChannel <= chanW'(`DMA_CHANNELS - 1);
    else if (svcUpdate)
      lastChannel <= svcChannel;
  end

  // scan from the highest priority channel, first pending one wins
  always_comb
  begin
    logic [chanW-1:0] startChannel;
    logic [chanW-1:0] idx;
    logic             found;
    startChannel = rotatingPriority ? chanW'(lastChannel + 1'b1) : '0;
    winner       = '0;
    found        = 1'b0;
    for (int k = 0; k < `DMA_CHANNELS; k++)
    begin
      idx = chanW'(startChannel + k);
      if (!found && dreq[idx])
      begin
        winner[idx] = 1'b1;
        found       = 1'b1;
      end
    end
  end

endmodule

//--- rtl/dmaTimingControl.sv
`timescale 1ns/1ps
`include "dma_config.svh"

module dmaTimingControl
  import dmaBusPkg::*, dmaRegPkg::*;
(
  input  logic                             cpuIf,
  input  logic                             rstN,
  input  logic [`DMA_CHANNELS-1:0]         dreq,
  input  logic                             hlda,
  input  dmaCommandT                       commandReg,
  input  dmaModeT                          svcMode,
  input  logic                             tcNow,
  input  logic [`DMA_CHANNELS-1:0]         winner,
  output logic                             hrq,
  output logic [`DMA_CHANNELS-1:0]         dack,
  output logic                             memrN,
  output logic                             memwN,
  output logic                             eopN,
  output logic                             programEn,
  output logic [$clog2(`DMA_CHANNELS)-1:0] svcChannel,
  output logic                             svcUpdate
);

  localparam int chanW = $clog2(`DMA_CHANNELS);

  typedef enum logic [2:0]
  {
    stIdle,
    stRequest,
    stS1,
    stS2,
    stS3
  } dmaStateT;

  dmaStateT         state;
  logic [chanW-1:0] channelReg;
  logic [chanW-1:0] winnerIdx;
  logic             inCycle;

  // one-hot winner to channel number
  always_comb
  begin
    winnerIdx = '0;
    for (int i = 0; i < `DMA_CHANNELS; i++)
    begin
      if (winner[i])
        winnerIdx = chanW'(i);
    end
  end

  always_ff @(posedge cpuIf)
  begin
    if (!rstN)
    begin
      state      <= stIdle;
      channelReg <= '0;
    end
    else
    begin
      case (state)
        stIdle:
          if ((|dreq) && !commandReg.controllerDisable)
            state <= stRequest;
        // hold hrq as long as the bus is not granted
        stRequest:
          if (hlda)
          begin
            if (|winner)
            begin
              channelReg <= winnerIdx;
              state      <= stS1;
            end
            else
              state <= stIdle;
          end
        stS1:
          state <= stS2;
        stS2:
          state <= stS3;
        stS3:
          if (svcMode.transferMode == modeBlock && !tcNow)
            state <= stS1;
          else
            state <= stIdle;
        default:
          state <= stIdle;
      endcase
    end
  end

  assign inCycle = (state == stS1) || (state == stS2) || (state == stS3);

  always_comb
  begin
    dack = '0;
    if (inCycle)
      dack[channelReg] = 1'b1;
  end

  assign hrq        = (state != stIdle);
  assign programEn  = (state == stIdle);
  assign svcChannel = channelReg;
  assign svcUpdate  = (state == stS3);

  // verify cycles run without a strobe
  assign memwN = !((state == stS2) && (svcMode.transferType == typeWrite));
  assign memrN = !((state == stS2) && (svcMode.transferType == typeRead));
  assign eopN  = !((state == stS3) && tcNow);

endmodule

//--- rtl/dmaController.sv
`timescale 1ns/1ps
`include "dma_config.svh"

module dmaController
  import dmaRegPkg::*;
(
  input  logic                        cpuIf,
  input  logic                        rstN,
  input  logic                        csN,
  input  logic                        iorN,
  input  logic                        iowN,
  input  logic [3:0]                  addrLow,
  input  logic [`DMA_DATA_WIDTH-1:0]  dbIn,
  output logic [`DMA_DATA_WIDTH-1:0]  dbOut,
  output logic                        dbOutEn,
  input  logic [`DMA_CHANNELS-1:0]    dreq,
  input  logic                        hlda,
  output logic                        hrq,
  output logic [`DMA_CHANNELS-1:0]    dack,
  output logic [`DMA_ADDR_WIDTH-1:0]  memAddr,
  output logic                        memrN,
  output logic                        memwN,
  output logic                        eopN
);

  dmaCommandT                       commandReg;
  dmaModeT                          svcMode;
  logic                             tcNow;
  logic [`DMA_CHANNELS-1:0]         winner;
  logic                             programEn;
  logic [$clog2(`DMA_CHANNELS)-1:0] svcChannel;
  logic                             svcUpdate;

  dmaDatapath dmaDatapath_i
  (
    .cpuIf      (cpuIf),
    .rstN       (rstN),
    .csN        (csN),
    .iorN       (iorN),
    .iowN       (iowN),
    .addrLow    (addrLow),
    .dbIn       (dbIn),
    .dbOut      (dbOut),
    .dbOutEn    (dbOutEn),
    .dreq       (dreq),
    .programEn  (programEn),
    .svcChannel (svcChannel),
    .svcUpdate  (svcUpdate),
    .commandReg (commandReg),
    .svcMode    (svcMode),
    .memAddr    (memAddr),
    .tcNow      (tcNow)
  );

  dmaPriority dmaPriority_i
  (
    .cpuIf            (cpuIf),
    .rstN             (rstN),
    .dreq             (dreq),
    .rotatingPriority (commandReg.rotatingPriority),
    .svcUpdate        (svcUpdate),
    .svcChannel       (svcChannel),
    .winner           (winner)
  );

  dmaTimingControl dmaTimingControl_i
  (
    .cpuIf      (cpuIf),
    .rstN       (rstN),
    .dreq       (dreq),
    .hlda       (hlda),
    .commandReg (commandReg),
    .svcMode    (svcMode),
    .tcNow      (tcNow),
    .winner     (winner),
    .hrq        (hrq),
    .dack       (dack),
    .memrN      (memrN),
    .memwN      (memwN),
    .eopN       (eopN),
    .programEn  (programEn),
    .svcChannel (svcChannel),
    .svcUpdate  (svcUpdate)
  );

endmodule

//--- bench/dmaController_asserts.sv
`timescale 1ns/1ps
`include "dma_config.svh"

module dmaControllerAsserts
(
  input logic                     cpuIf,
  input logic                     rstN,
  input logic                     hlda,
  input logic                     hrq,
  input logic [`DMA_CHANNELS-1:0] dack,
  input logic                     memrN,
  input logic                     memwN,
  input logic                     eopN
);

  // count of failed properties
  int failCount = 0;

  dackOneHot: assert property (@(posedge cpuIf) disable iff (!rstN) $onehot0(dack))
    else
    begin
      failCount++;
      $error("dack has more than one channel: %b", dack);
    end

  // acknowledge only while the bus is granted
  dackWithHlda: assert property (@(posedge cpuIf) disable iff (!rstN) (dack != '0) |-> hlda)
    else
    begin
      failCount++;
      $error("dack high without hlda");
    end

  strobesExclusive: assert property (@(posedge cpuIf) disable iff (!rstN) !(!memrN && !memwN))
    else
    begin
      failCount++;
      $error("memrN and memwN low together");
    end

  eopWithDack: assert property (@(posedge cpuIf) disable iff (!rstN) !eopN |-> (dack != '0))
    else
    begin
      failCount++;
      $error("eopN low with no channel acknowledged");
    end

  // first cycle out of reset
  hrqLowAfterReset: assert property (@(posedge cpuIf) $rose(rstN) |-> !hrq)
    else
    begin
      failCount++;
      $error("hrq high right after reset");
    end

endmodule

//--- bench/dmaControllerTb.sv
`timescale 1ns/1ps
`include "dma_config.svh"

module dmaControllerTb
  import dmaBusPkg::*, dmaRegPkg::*;
();

  localparam int opWrite = 0;
  localparam int opRead = 1;
  localparam int opTransfer = 2;
  localparam int opNoRequest = 3;
  localparam int waitLimit = 400;
  localparam int quietCycles = 50;

  // one table entry, fields unused by an op stay zero
  typedef struct packed
  {
    int          test;
    int          op;
    logic [3:0]  addr;
    logic [7:0]  data;
    logic [3:0]  dreqSet;
    logic [7:0]  order;
    logic [15:0] firstAddr;
    logic [15:0] lastAddr;
    logic        readStrobe;
    int          count;
    int          episodes;
    logic        expectEop;
  } stepT;

  logic                         cpuIf;
  logic                         rstN;
  logic                         csN;
  logic                         iorN;
  logic                         iowN;
  logic [3:0]                   addrLow;
  logic [`DMA_DATA_WIDTH-1:0]   dbIn;
  logic [`DMA_DATA_WIDTH-1:0]   dbOut;
  logic                         dbOutEn;
  logic [`DMA_CHANNELS-1:0]     dreq;
  logic                         hlda;
  logic                         hrq;
  logic [`DMA_CHANNELS-1:0]     dack;
  logic [`DMA_ADDR_WIDTH-1:0]   memAddr;
  logic                         memrN;
  logic                         memwN;
  logic                         eopN;
  logic [1:0]                   hldaWait;

  stepT  steps [128];
  int    stepCount;
  string testNames [6] = '{"register access", "single-mode write", "block-mode read down",
                           "fixed and rotating priority", "auto-initialize",
                           "controller disable"};
  int    testErrors;
  int    errorCount;
  int    passedTests;
  int    failedTests;

  logic [15:0] strobeAddr [$];
  logic [3:0]  strobeDack [$];
  logic        strobeRead [$];
  int          eopCount;
  int          eopAt;
  int          hrqEpisodes;
  logic        hrqSeen;

  dmaController dmaController_i
  (
    .cpuIf   (cpuIf),
    .rstN    (rstN),
    .csN     (csN),
    .iorN    (iorN),
    .iowN    (iowN),
    .addrLow (addrLow),
    .dbIn    (dbIn),
    .dbOut   (dbOut),
    .dbOutEn (dbOutEn),
    .dreq    (dreq),
    .hlda    (hlda),
    .hrq     (hrq),
    .dack    (dack),
    .memAddr (memAddr),
    .memrN   (memrN),
    .memwN   (memwN),
    .eopN    (eopN)
  );

  bind dmaController dmaControllerAsserts dmaControllerAsserts_i
  (
    .cpuIf (cpuIf),
    .rstN  (rstN),
    .hlda  (hlda),
    .hrq   (hrq),
    .dack  (dack),
    .memrN (memrN),
    .memwN (memwN),
    .eopN  (eopN)
  );

  always #2 cpuIf = ~cpuIf;

  // bus grant two cycles after hrq, released with it
  always @(posedge cpuIf)
  begin
    if (!hrq)
    begin
      hlda     <= 1'b0;
      hldaWait <= 2'd0;
    end
    else if (hldaWait == 2'd1)
      hlda <= 1'b1;
    else
      hldaWait <= hldaWait + 2'd1;
  end

  // strobes, eop and hrq episodes, sampled mid-cycle
  always @(negedge cpuIf)
  begin
    if (rstN)
    begin
      if (!memwN || !memrN)
      begin
        strobeAddr.push_back(memAddr);
        strobeDack.push_back(dack);
        strobeRead.push_back(!memrN);
      end
      if (!eopN)
      begin
        eopCount++;
        eopAt = strobeAddr.size();
      end
      if (hrq && !hrqSeen)
        hrqEpisodes++;
      hrqSeen = hrq;
    end
  end

  task automatic checkEqual(input string what, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("ERROR %0t ns: %s expected %0h, got %0h", $time, what, expected, actual);
      testErrors++;
    end
  endtask

  function automatic logic [7:0] modeByte(input logic [1:0] channel, input transferModeE tMode,
                                          input logic decrement, input logic autoInit,
                                          input transferTypeE tType);
    dmaWriteByteT b;
    b.modeWrite.channel            = channel;
    b.modeWrite.mode.transferMode  = tMode;
    b.modeWrite.mode.addrDecrement = decrement;
    b.modeWrite.mode.autoInit      = autoInit;
    b.modeWrite.mode.transferType  = tType;
    return b.raw;
  endfunction

  function automatic void addAccess(input int test, input int op, input logic [3:0] addr,
                                    input logic [7:0] data);
    stepT s;
    s      = '0;
    s.test = test;
    s.op   = op;
    s.addr = addr;
    s.data = data;
    steps[stepCount] = s;
    stepCount++;
  endfunction

  // low byte first, then high byte
  function automatic void addWord(input int test, input int op, input logic [3:0] addr,
                                  input logic [15:0] word);
    addAccess(test, op, addr, word[7:0]);
    addAccess(test, op, addr, word[15:8]);
  endfunction

  function automatic void addTransfer(input int test, input logic [3:0] dreqSet,
                                      input logic [7:0] order, input logic [15:0] firstAddr,
                                      input logic [15:0] lastAddr, input logic readStrobe,
                                      input int count, input int episodes,
                                      input logic expectEop);
    stepT s;
    s            = '0;
    s.test       = test;
    s.op         = opTransfer;
    s.dreqSet    = dreqSet;
    s.order      = order;
    s.firstAddr  = firstAddr;
    s.lastAddr   = lastAddr;
    s.readStrobe = readStrobe;
    s.count      = count;
    s.episodes   = episodes;
    s.expectEop  = expectEop;
    steps[stepCount] = s;
    stepCount++;
  endfunction

  function automatic void buildTable();
    logic [15:0] addrVal [4];
    logic [15:0] countVal [4];
    logic [15:0] a2;
    logic [15:0] a3;
    logic [15:0] a0;
    logic [15:0] b2;
    logic [15:0] a5;
    logic [7:0]  lowByte;
    for (int ch = 0; ch < 4; ch++)
    begin
      addrVal[ch]  = 16'($urandom());
      countVal[ch] = 16'($urandom());
    end
    addAccess(1, opWrite, 4'd12, 8'h00);
    for (int ch = 0; ch < 4; ch++)
    begin
      addWord(1, opWrite, 4'(2 * ch), addrVal[ch]);
      addWord(1, opWrite, 4'(2 * ch + 1), countVal[ch]);
    end
    for (int ch = 0; ch < 4; ch++)
    begin
      addWord(1, opRead, 4'(2 * ch), addrVal[ch]);
      addWord(1, opRead, 4'(2 * ch + 1), countVal[ch]);
    end
    // stray low byte, then clear, so the next read starts at the low byte
    lowByte = 8'($urandom());
    addAccess(1, opWrite, 4'd0, ~addrVal[0][15:8]);
    addAccess(1, opWrite, 4'd12, 8'h00);
    addWord(1, opRead, 4'd0, {addrVal[0][15:8], ~addrVal[0][15:8]});
    addWord(1, opWrite, 4'd0, {addrVal[0][15:8], lowByte});
    addWord(1, opRead, 4'd0, {addrVal[0][15:8], lowByte});

    // count 2 means three transfers
    a2 = 16'($urandom());
    addAccess(2, opWrite, 4'd12, 8'h00);
    addAccess(2, opWrite, 4'd11, modeByte(2'd1, modeSingle, 1'b0, 1'b0, typeWrite));
    addWord(2, opWrite, 4'd2, a2);
    addWord(2, opWrite, 4'd3, 16'd2);
    addTransfer(2, 4'b0010, 8'b01_01_01_01, a2, a2 + 16'd2, 1'b0, 3, 3, 1'b1);

    a3 = 16'($urandom());
    addAccess(3, opWrite, 4'd11, modeByte(2'd2, modeBlock, 1'b1, 1'b0, typeRead));
    addWord(3, opWrite, 4'd4, a3);
    addWord(3, opWrite, 4'd5, 16'd3);
    addTransfer(3, 4'b0100, 8'b10_10_10_10, a3, a3 - 16'd3, 1'b1, 4, 1, 1'b1);
    // channel 1 still flags its terminal count from test 2
    addAccess(3, opRead, 4'd8, 8'h06);
    addAccess(3, opRead, 4'd8, 8'h00);

    // counts of 256 and up stay clear of terminal count
    a0 = 16'($urandom());
    b2 = 16'($urandom());
    addAccess(4, opWrite, 4'd11, modeByte(2'd0, modeSingle, 1'b0, 1'b0, typeWrite));
    addAccess(4, opWrite, 4'd11, modeByte(2'd2, modeSingle, 1'b0, 1'b0, typeWrite));
    addWord(4, opWrite, 4'd0, a0);
    addWord(4, opWrite, 4'd1, 16'h0100 | 16'($urandom()));
    addWord(4, opWrite, 4'd4, b2);
    addWord(4, opWrite, 4'd5, 16'h0100 | 16'($urandom()));
    addTransfer(4, 4'b0101, 8'h00, a0, a0 + 16'd3, 1'b0, 4, 4, 1'b0);
    addAccess(4, opWrite, 4'd8, 8'h10);
    // channel 0 was served last, so channel 2 leads
    addTransfer(4, 4'b0101, 8'b00_10_00_10, b2, a0 + 16'd5, 1'b0, 4, 4, 1'b0);
    addAccess(4, opWrite, 4'd8, 8'h00);

    a5 = 16'($urandom());
    addAccess(5, opWrite, 4'd11, modeByte(2'd3, modeBlock, 1'b0, 1'b1, typeWrite));
    addWord(5, opWrite, 4'd6, a5);
    addWord(5, opWrite, 4'd7, 16'd1);
    addTransfer(5, 4'b1000, 8'b11_11_11_11, a5, a5 + 16'd1, 1'b0, 2, 1, 1'b1);
    addWord(5, opRead, 4'd6, a5);
    addWord(5, opRead, 4'd7, 16'd1);

    addAccess(6, opWrite, 4'd8, 8'h04);
    addTransfer(6, 4'b0001, 8'h00, 16'h0, 16'h0, 1'b0, 0, 0, 1'b0);
    steps[stepCount - 1].op = opNoRequest;
    addAccess(6, opWrite, 4'd8, 8'h00);
  endfunction

  task automatic writeReg(input logic [3:0] addr, input logic [7:0] data);
    @(posedge cpuIf);
    csN     <= 1'b0;
    iowN    <= 1'b0;
    addrLow <= addr;
    dbIn    <= data;
    @(posedge cpuIf);
    csN  <= 1'b1;
    iowN <= 1'b1;
  endtask

  // data comes back in the cycle after the strobe
  task automatic readReg(input logic [3:0] addr, input logic [7:0] expected);
    @(posedge cpuIf);
    csN     <= 1'b0;
    iorN    <= 1'b0;
    addrLow <= addr;
    @(posedge cpuIf);
    csN  <= 1'b1;
    iorN <= 1'b1;
    @(negedge cpuIf);
    checkEqual("read data enable", dbOutEn, 1'b1);
    checkEqual($sformatf("read byte at register %0d", addr), dbOut, expected);
  endtask

  task automatic waitIdle();
    int cycles;
    cycles = 0;
    while (hrq && cycles < waitLimit)
    begin
      @(negedge cpuIf);
      cycles++;
    end
    if (hrq)
    begin
      $display("timeout: hrq still high after %0d cycles", waitLimit);
      testErrors++;
    end
  endtask

  task automatic runTransfer(input stepT s);
    int         cycles;
    logic [1:0] chan;
    @(posedge cpuIf);
    strobeAddr.delete();
    strobeDack.delete();
    strobeRead.delete();
    eopCount    = 0;
    eopAt       = 0;
    hrqEpisodes = 0;
    dreq <= s.dreqSet;
    cycles = 0;
    while (strobeAddr.size() < s.count && cycles < waitLimit)
    begin
      @(posedge cpuIf);
      cycles++;
    end
    dreq <= '0;
    if (strobeAddr.size() < s.count)
    begin
      $display("timeout: saw %0d of %0d memory strobes", strobeAddr.size(), s.count);
      testErrors++;
    end
    waitIdle();
    checkEqual("transfer count", strobeAddr.size(), s.count);
    checkEqual("hrq episodes", hrqEpisodes, s.episodes);
    for (int i = 0; i < strobeAddr.size(); i++)
    begin
      if (i < 4)
      begin
        chan = s.order[2 * i +: 2];
        checkEqual($sformatf("dack of transfer %0d", i), strobeDack[i], 4'b0001 << chan);
      end
      checkEqual($sformatf("strobe kind of transfer %0d", i), strobeRead[i], s.readStrobe);
    end
    if (strobeAddr.size() > 0)
    begin
      checkEqual("first memAddr", strobeAddr[0], s.firstAddr);
      checkEqual("last memAddr", strobeAddr[strobeAddr.size() - 1], s.lastAddr);
    end
    checkEqual("eop pulses", eopCount, s.expectEop ? 1 : 0);
    if (s.expectEop)
      checkEqual("eop at transfer", eopAt, s.count);
  endtask

  task automatic expectNoRequest(input stepT s);
    int   cycles;
    logic raised;
    raised = 1'b0;
    @(posedge cpuIf);
    dreq <= s.dreqSet;
    for (cycles = 0; cycles < quietCycles; cycles++)
    begin
      @(negedge cpuIf);
      if (hrq)
        raised = 1'b1;
    end
    @(posedge cpuIf);
    dreq <= '0;
    waitIdle();
    checkEqual("hrq while disabled", raised, 1'b0);
  endtask

  task automatic finishTest(input int test);
    if (testErrors == 0)
    begin
      passedTests++;
      $display("test %0d (%s): pass", test, testNames[test - 1]);
    end
    else
    begin
      failedTests++;
      $display("test %0d (%s): fail, %0d mismatches", test, testNames[test - 1], testErrors);
    end
    errorCount += testErrors;
    testErrors = 0;
  endtask

  initial
  begin
    int assertFails;
    cpuIf    = 1'b0;
    rstN     = 1'b0;
    csN      = 1'b1;
    iorN     = 1'b1;
    iowN     = 1'b1;
    addrLow  = '0;
    dbIn     = '0;
    dreq     = '0;
    hlda     = 1'b0;
    hldaWait = 2'd0;
    hrqSeen  = 1'b0;
    void'($urandom(32'h469a_eb41));
    buildTable();
    repeat (16) @(posedge cpuIf);
    rstN <= 1'b1;
    for (int i = 0; i < stepCount; i++)
    begin
      case (steps[i].op)
        opWrite:
          writeReg(steps[i].addr, steps[i].data);
        opRead:
          readReg(steps[i].addr, steps[i].data);
        opTransfer:
          runTransfer(steps[i]);
        default:
          expectNoRequest(steps[i]);
      endcase
      if (i == stepCount - 1 || steps[i + 1].test != steps[i].test)
        finishTest(steps[i].test);
    end
    assertFails = dmaController_i.dmaControllerAsserts_i.failCount;
    $display("summary: %0d tests, %0d passed, %0d failed, %0d mismatches, %0d assertion errors",
             passedTests + failedTests, passedTests, failedTests, errorCount, assertFails);
    if (failedTests == 0 && errorCount == 0 && assertFails == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // bound on the whole run
  initial
  begin
    repeat (20000) @(posedge cpuIf);
    $display("simulation ran past its cycle limit");
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+rtl
rtl/dmaBusPkg.sv
rtl/dmaRegPkg.sv
rtl/dmaDatapath.sv
rtl/dmaPriority.sv
rtl/dmaTimingControl.sv
rtl/dmaController.sv
bench/dmaController_asserts.sv
bench/dmaControllerTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       ?= dmaControllerTb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
SIM       := $(OBJDIR)/V$(TOP)

SOURCES := $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJDIR)
